//--- dv/maze_game_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "maze_defines.svh"

module maze_game_tb import maze_pkg::*; ();

    localparam int TBL_N = 20;

    logic clk;
    logic nrst;
    logic start;
    logic btn_up;
    logic btn_down;
    logic btn_left;
    logic btn_right;
    game_state_e game_state;
    coord_t player_x;
    coord_t player_y;
    coord_t dest_x;
    coord_t dest_y;
    coord_t map_select;
    logic [`MAZE_CNT_W-1:0] move_count;

    move_op_e tbl_op [TBL_N];
    int tbl_idle [TBL_N];
    bit tbl_chk [TBL_N];
    int tbl_cycles;
    int limit;
    int cycles;
    int reset_edge;     // edge count when nrst went high

    // reference model of the round
    coord_t m_x;
    coord_t m_y;
    coord_t m_dx;
    coord_t m_dy;
    coord_t m_map;
    logic [`MAZE_CNT_W-1:0] m_cnt;
    game_state_e m_state;
    move_op_e path_ops [64];

    maze_game_top uut (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .game_state (game_state),
        .player_x   (player_x),
        .player_y   (player_y),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .map_select (map_select),
        .move_count (move_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Test FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_state(string name, game_state_e got, game_state_e exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_coord(string name, coord_t got, coord_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(string name, logic [`MAZE_CNT_W-1:0] got,
                               logic [`MAZE_CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // value of a 12 bit lfsr with taps 12, 6, 4 and 1 after n steps
    function automatic logic [11:0] lfsr_after(logic [11:0] seed, int n);
        logic [11:0] v;
        v = seed;
        for (int i = 0; i < n; i++) begin
            v = {v[10:0], v[11] ^ v[5] ^ v[3] ^ v[0]};
        end
        return v;
    endfunction

    // cell reached from x,y by op under the obstacle rule, packed {x, y}
    function automatic logic [5:0] next_pos(coord_t x, coord_t y, move_op_e op);
        int tx;
        int ty;
        bit blocked;
        tx = int'(x);
        ty = int'(y);
        case (op)
            MV_UP:    ty = ty + 1;
            MV_DOWN:  ty = ty - 1;
            MV_LEFT:  tx = tx - 1;
            MV_RIGHT: tx = tx + 1;
        endcase
        blocked = (tx < 0) || (tx > 7) || (ty < 0) || (ty > 7);
        if (!blocked && tx == int'(m_map) && (ty % 2) == 1
            && !(tx == int'(m_dx) && ty == int'(m_dy))) begin
            blocked = 1'b1;                 // odd row of the map column
        end
        if (blocked) begin
            return {x, y};
        end
        return {coord_t'(tx), coord_t'(ty)};
    endfunction

    task automatic apply_model(move_op_e op);
        logic [5:0] p;
        if (m_state == PLAY) begin
            p = next_pos(m_x, m_y, op);
            m_x = p[5:3];
            m_y = p[2:0];
            m_cnt = m_cnt + 1'b1;
            if (m_x == m_dx && m_y == m_dy) begin
                m_state = WON;
            end else if (m_cnt == `MAZE_CNT_W'(`MAZE_MAX_MOVES)) begin
                m_state = LOST;
            end
        end
    endtask

    task automatic set_btn(move_op_e op, logic level);
        case (op)
            MV_UP:    btn_up <= level;
            MV_DOWN:  btn_down <= level;
            MV_LEFT:  btn_left <= level;
            MV_RIGHT: btn_right <= level;
        endcase
    endtask

    task automatic check_all();
        check_state("game_state", game_state, m_state);
        check_coord("player_x", player_x, m_x);
        check_coord("player_y", player_y, m_y);
        check_count("move_count", move_count, m_cnt);
    endtask

    // one press held for a cycle, timed presses check the 3 cycle latency
    task automatic press(move_op_e op, bit timed, int idle);
        coord_t ox;
        coord_t oy;
        ox = m_x;
        oy = m_y;
        apply_model(op);
        @(posedge clk);
        set_btn(op, 1'b1);
        @(posedge clk);                     // press sampled here
        set_btn(op, 1'b0);
        if (timed) begin
            repeat (2) @(posedge clk);
            #1;
            check_coord("player_x", player_x, ox);
            check_coord("player_y", player_y, oy);
            @(posedge clk);
            #1;
            check_all();
        end
        repeat (idle) @(posedge clk);
    endtask

    task automatic drain_and_check();
        repeat (5) @(posedge clk);
        #1;
        check_all();
    endtask

    task automatic pulse_start(game_state_e exp_next);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        #1;
        check_state("game_state", game_state, exp_next);
    endtask

    task automatic start_round();
        logic [11:0] s_r;
        logic [11:0] d_r;
        logic [11:0] m_r;
        coord_t ex;
        coord_t ey;
        int n;
        pulse_start(LOAD);
        n = cycles - reset_edge - 1;        // lfsr steps before the capturing edge
        s_r = lfsr_after(12'd4069, n);
        d_r = lfsr_after(12'd3011, n);
        m_r = lfsr_after(12'd2393, n);
        ex = s_r[2:0];
        ey = s_r[5:3];
        if (ex == d_r[2:0] && ey == d_r[5:3]) begin
            ex = (d_r[2:0] == '0) ? coord_t'(`MAZE_ALT_START_X) : '0;
            ey = (d_r[5:3] == '0) ? coord_t'(`MAZE_ALT_START_Y) : '0;
        end
        @(posedge clk);
        #1;
        check_state("game_state", game_state, PLAY);
        check_count("move_count", move_count, '0);
        if (player_x == dest_x && player_y == dest_y) begin
            $display("start cell lands on the destination at the round start");
            stop_on_error();
        end
        check_coord("dest_x", dest_x, d_r[2:0]);
        check_coord("dest_y", dest_y, d_r[5:3]);
        check_coord("map_select", map_select, m_r[2:0]);
        check_coord("player_x", player_x, ex);
        check_coord("player_y", player_y, ey);
        m_x = player_x;                     // start cell seen at first PLAY cycle
        m_y = player_y;
        m_dx = dest_x;
        m_dy = dest_y;
        m_map = map_select;
        m_cnt = '0;
        m_state = PLAY;
    endtask

    // breadth first search from the player to the destination
    task automatic find_path(output int len);
        int q [64];
        int par [64];
        move_op_e par_op [64];
        move_op_e rev [64];
        bit seen [64];
        int head;
        int tail;
        int cur;
        int nxt;
        logic [5:0] p;
        head = 0;
        tail = 0;
        foreach (seen[i]) seen[i] = 1'b0;
        q[tail++] = int'({m_x, m_y});
        seen[int'({m_x, m_y})] = 1'b1;
        while (head < tail) begin
            cur = q[head++];
            for (int i = 0; i < 4; i++) begin
                p = next_pos(coord_t'(cur >> 3), coord_t'(cur & 7), move_op_e'(i));
                nxt = int'(p);
                if (!seen[nxt]) begin
                    seen[nxt] = 1'b1;
                    par[nxt] = cur;
                    par_op[nxt] = move_op_e'(i);
                    q[tail++] = nxt;
                end
            end
        end
        len = 0;
        cur = int'({m_dx, m_dy});
        while (cur != int'({m_x, m_y})) begin
            rev[len++] = par_op[cur];
            cur = par[cur];
        end
        for (int i = 0; i < len; i++) begin
            path_ops[i] = rev[len - 1 - i];
        end
    endtask

    initial begin
        int plen;
        logic [5:0] p;
        move_op_e op;
        nrst = 1'b0;
        start = 1'b0;
        btn_up = 1'b0;
        btn_down = 1'b0;
        btn_left = 1'b0;
        btn_right = 1'b0;
        cycles = 0;

        // checked single moves toward the edges, then a busy burst every second cycle
        tbl_op[0] = MV_LEFT;
        tbl_op[1] = MV_LEFT;
        tbl_op[2] = MV_LEFT;
        tbl_op[3] = MV_DOWN;
        tbl_op[4] = MV_DOWN;
        tbl_op[5] = MV_DOWN;
        tbl_op[6] = MV_RIGHT;
        tbl_op[7] = MV_UP;
        for (int i = 0; i < TBL_N; i++) begin
            if (i >= 8) tbl_op[i] = (i % 2) ? MV_UP : MV_RIGHT;
            tbl_chk[i] = (i < 8);
            tbl_idle[i] = (i < 8) ? 1 : 0;
        end
        tbl_cycles = 0;
        for (int i = 0; i < TBL_N; i++) begin
            tbl_cycles += (tbl_chk[i] ? 5 : 2) + tbl_idle[i];
        end
        limit = 4 * tbl_cycles + 200;

        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        #1;
        reset_edge = cycles;
        check_state("game_state", game_state, MENU);
        check_coord("player_x", player_x, coord_t'(`MAZE_RST_START_X));
        check_coord("player_y", player_y, coord_t'(`MAZE_RST_START_Y));
        check_coord("dest_x", dest_x, coord_t'(`MAZE_RST_DEST_X));
        check_coord("dest_y", dest_y, coord_t'(`MAZE_RST_DEST_Y));
        check_coord("map_select", map_select, '0);
        check_count("move_count", move_count, '0);

        // round one, table driven moves
        start_round();
        for (int i = 0; i < TBL_N; i++) begin
            press(tbl_op[i], tbl_chk[i], tbl_idle[i]);
        end
        drain_and_check();
        pulse_start(MENU);

        // round two, shortest path to the destination
        start_round();
        find_path(plen);
        for (int i = 0; i < plen; i++) begin
            press(path_ops[i], 1'b0, 1);
        end
        drain_and_check();
        check_state("game_state", game_state, WON);
        for (int i = 0; i < 3; i++) press(move_op_e'(i), 1'b0, 1);
        drain_and_check();                   // frozen after the win
        pulse_start(MENU);

        // round three, wander without reaching the destination
        start_round();
        while (m_state == PLAY) begin
            op = (m_cnt[0]) ? MV_DOWN : MV_UP;
            for (int i = 0; i < 4; i++) begin
                p = next_pos(m_x, m_y, op);
                if (p == {m_dx, m_dy}) op = move_op_e'((int'(op) + 1) % 4);
            end
            press(op, 1'b0, 1);
        end
        drain_and_check();
        check_state("game_state", game_state, LOST);
        check_count("move_count", move_count, `MAZE_CNT_W'(`MAZE_MAX_MOVES));

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- maze_game.f
+incdir+rtl
rtl/maze_pkg.sv
rtl/maze_lfsr.sv
rtl/maze_pos_gen.sv
rtl/move_cmd_gen.sv
rtl/move_queue.sv
rtl/player_ctrl.sv
rtl/maze_game_top.sv
dv/maze_game_tb.sv

//--- rtl/maze_defines.svh
`ifndef MAZE_DEFINES_SVH
`define MAZE_DEFINES_SVH

// grid geometry
`define MAZE_GRID_SIZE    8
`define MAZE_COORD_W      3

// move link and budget
`define MAZE_QUEUE_DEPTH  4
`define MAZE_MAX_MOVES    20
`define MAZE_CNT_W        5   // wide enough for the move budget

// positions held after reset
`define MAZE_RST_START_X  5
`define MAZE_RST_START_Y  2
`define MAZE_RST_DEST_X   3
`define MAZE_RST_DEST_Y   3

// start cell used when start and destination collide
`define MAZE_ALT_START_X  3
`define MAZE_ALT_START_Y  4

`endif

//--- rtl/maze_game_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "maze_defines.svh"

module maze_game_top import maze_pkg::*; (
    input  wire logic   clk,
    input  wire logic   nrst,
    input  wire logic   start,
    input  wire logic   btn_up,
    input  wire logic   btn_down,
    input  wire logic   btn_left,
    input  wire logic   btn_right,
    output game_state_e game_state,
    output coord_t      player_x,
    output coord_t      player_y,
    output coord_t      dest_x,
    output coord_t      dest_y,
    output coord_t      map_select,
    output logic [`MAZE_CNT_W-1:0] move_count
);

    logic     activate_rand;
    coord_t   start_x;
    coord_t   start_y;
    logic     cmd_valid;
    move_op_e cmd;
    logic     credit_return;
    logic     q_valid;
    move_op_e q_cmd;
    logic     q_pop;

    maze_pos_gen u_pos_gen (
        .clk           (clk),
        .nrst          (nrst),
        .activate_rand (activate_rand),
        .map_select    (map_select),
        .start_x       (start_x),
        .start_y       (start_y),
        .dest_x        (dest_x),
        .dest_y        (dest_y)
    );

    move_cmd_gen u_cmd_gen (
        .clk           (clk),
        .nrst          (nrst),
        .btn_up        (btn_up),
        .btn_down      (btn_down),
        .btn_left      (btn_left),
        .btn_right     (btn_right),
        .credit_return (credit_return),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd)
    );

    move_queue u_queue (
        .clk           (clk),
        .nrst          (nrst),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .q_pop         (q_pop),
        .q_valid       (q_valid),
        .q_cmd         (q_cmd),
        .credit_return (credit_return)
    );

    player_ctrl u_player (
        .clk           (clk),
        .nrst          (nrst),
        .start         (start),
        .q_valid       (q_valid),
        .q_cmd         (q_cmd),
        .start_x       (start_x),
        .start_y       (start_y),
        .dest_x        (dest_x),
        .dest_y        (dest_y),
        .map_select    (map_select),
        .q_pop         (q_pop),
        .activate_rand (activate_rand),
        .game_state    (game_state),
        .player_x      (player_x),
        .player_y      (player_y),
        .move_count    (move_count)
    );

endmodule

`default_nettype wire

//--- rtl/maze_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

module maze_lfsr import maze_pkg::*; #(
    parameter logic [11:0] SEED = 12'h001   // must not be zero
) (
    input  wire logic        clk,
    input  wire logic        nrst,
    output logic      [11:0] rand_val
);

    logic feedback;

    // taps 12, 6, 4 and 1 of the fibonacci form
    assign feedback = rand_val[11] ^ rand_val[5] ^ rand_val[3] ^ rand_val[0];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rand_val <= SEED;
        end else begin
            rand_val <= {rand_val[10:0], feedback};   // steps every cycle
        end
    end

endmodule

`default_nettype wire

//--- rtl/maze_pkg.sv
`default_nettype none

`include "maze_defines.svh"

package maze_pkg;

    // one grid coordinate, also used for the map number
    typedef logic [`MAZE_COORD_W-1:0] coord_t;

    // round progress of the game
    typedef enum logic [2:0] {
        MENU = 3'd0,    // waiting for start
        LOAD = 3'd1,    // copy start cell into player
        PLAY = 3'd2,
        WON  = 3'd3,
        LOST = 3'd4
    } game_state_e;

    // move commands carried over the credit link
    typedef enum logic [1:0] {
        MV_UP    = 2'd0,    // y + 1
        MV_DOWN  = 2'd1,    // y - 1
        MV_LEFT  = 2'd2,    // x - 1
        MV_RIGHT = 2'd3     // x + 1
    } move_op_e;

endpackage

`default_nettype wire

//--- rtl/maze_pos_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "maze_defines.svh"

module maze_pos_gen import maze_pkg::*; (
    input  wire logic   clk,
    input  wire logic   nrst,
    input  wire logic   activate_rand,
    output coord_t      map_select,
    output coord_t      start_x,
    output coord_t      start_y,
    output coord_t      dest_x,
    output coord_t      dest_y
);

    logic [11:0] start_rand;
    logic [11:0] dest_rand;
    logic [11:0] map_rand;

    coord_t rnd_start_x;
    coord_t rnd_start_y;
    coord_t rnd_dest_x;
    coord_t rnd_dest_y;
    logic   overlap;

    maze_lfsr #(.SEED(12'd4069)) u_start_lfsr (
        .clk      (clk),
        .nrst     (nrst),
        .rand_val (start_rand)
    );

    maze_lfsr #(.SEED(12'd3011)) u_dest_lfsr (
        .clk      (clk),
        .nrst     (nrst),
        .rand_val (dest_rand)
    );

    maze_lfsr #(.SEED(12'd2393)) u_map_lfsr (
        .clk      (clk),
        .nrst     (nrst),
        .rand_val (map_rand)
    );

    assign rnd_start_x = start_rand[2:0];
    assign rnd_start_y = start_rand[5:3];
    assign rnd_dest_x  = dest_rand[2:0];
    assign rnd_dest_y  = dest_rand[5:3];

    assign overlap = (rnd_start_x == rnd_dest_x) && (rnd_start_y == rnd_dest_y);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            map_select <= '0;
            start_x    <= coord_t'(`MAZE_RST_START_X);
            start_y    <= coord_t'(`MAZE_RST_START_Y);
            dest_x     <= coord_t'(`MAZE_RST_DEST_X);
            dest_y     <= coord_t'(`MAZE_RST_DEST_Y);
        end else if (activate_rand) begin   // same edge as MENU -> LOAD
            map_select <= map_rand[2:0];
            dest_x     <= rnd_dest_x;
            dest_y     <= rnd_dest_y;
            if (overlap) begin
                // move the start off the destination on both axes
                start_x <= (rnd_dest_x == '0) ? coord_t'(`MAZE_ALT_START_X) : '0;
                start_y <= (rnd_dest_y == '0) ? coord_t'(`MAZE_ALT_START_Y) : '0;
            end else begin
                start_x <= rnd_start_x;
                start_y <= rnd_start_y;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/move_cmd_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "maze_defines.svh"

module move_cmd_gen import maze_pkg::*; (
    input  wire logic   clk,
    input  wire logic   nrst,
    input  wire logic   btn_up,
    input  wire logic   btn_down,
    input  wire logic   btn_left,
    input  wire logic   btn_right,
    input  wire logic   credit_return,
    output logic        cmd_valid,
    output move_op_e    cmd
);

    localparam int CRED_W = $clog2(`MAZE_QUEUE_DEPTH + 1);

    logic [3:0]        btn_q;      // sampled levels, {right, left, down, up}
    logic [3:0]        btn_prev;
    logic [3:0]        btn_rise;
    logic [CRED_W-1:0] credits;
    logic              send;
    move_op_e          next_cmd;

    assign btn_rise = btn_q & ~btn_prev;

    // up wins over down, down over left, left over right
    always_comb begin
        next_cmd = MV_RIGHT;
        if (btn_rise[0]) begin
            next_cmd = MV_UP;
        end else if (btn_rise[1]) begin
            next_cmd = MV_DOWN;
        end else if (btn_rise[2]) begin
            next_cmd = MV_LEFT;
        end
    end

    assign send = (|btn_rise) && (credits != '0);   // no credit, press is dropped

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            btn_q    <= '0;
            btn_prev <= '0;
        end else begin
            btn_q    <= {btn_right, btn_left, btn_down, btn_up};
            btn_prev <= btn_q;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_valid <= 1'b0;
            credits   <= CRED_W'(`MAZE_QUEUE_DEPTH);
        end else begin
            cmd_valid <= send;
            credits   <= credits - CRED_W'(send) + CRED_W'(credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

//--- rtl/move_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "maze_defines.svh"

module move_queue import maze_pkg::*; (
    input  wire logic       clk,
    input  wire logic       nrst,
    input  wire logic       cmd_valid,
    input  wire move_op_e   cmd,
    input  wire logic       q_pop,
    output logic            q_valid,
    output move_op_e        q_cmd,
    output logic            credit_return
);

    localparam int DEPTH = `MAZE_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    move_op_e          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_pop;

    assign q_valid = (count != '0);
    assign q_cmd   = mem[rd_ptr];        // head entry
    assign do_pop  = q_pop && q_valid;

    // credits guarantee room, so a push never meets a full queue
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count         <= count + CNT_W'(cmd_valid) - CNT_W'(do_pop);
            credit_return <= do_pop;    // one credit per popped entry
        end
    end

endmodule

`default_nettype wire

//--- rtl/player_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "maze_defines.svh"

module player_ctrl import maze_pkg::*; (
    input  wire logic       clk,
    input  wire logic       nrst,
    input  wire logic       start,
    input  wire logic       q_valid,
    input  wire move_op_e   q_cmd,
    input  wire coord_t     start_x,
    input  wire coord_t     start_y,
    input  wire coord_t     dest_x,
    input  wire coord_t     dest_y,
    input  wire coord_t     map_select,
    output logic            q_pop,
    output logic            activate_rand,
    output game_state_e     game_state,
    output coord_t          player_x,
    output coord_t          player_y,
    output logic [`MAZE_CNT_W-1:0] move_count
);

    localparam coord_t EDGE_HI = coord_t'(`MAZE_GRID_SIZE - 1);

    coord_t                 tgt_x;
    coord_t                 tgt_y;
    logic                   off_grid;
    logic                   tgt_is_dest;
    logic                   obstacle;
    coord_t                 new_x;
    coord_t                 new_y;
    logic [`MAZE_CNT_W-1:0] next_count;

    assign q_pop         = q_valid;     // drains one entry every cycle
    assign activate_rand = (game_state == MENU) && start;

    // target cell and whether it would leave the grid
    always_comb begin
        tgt_x    = player_x;
        tgt_y    = player_y;
        off_grid = 1'b0;
        case (q_cmd)
            MV_UP: begin
                tgt_y    = player_y + 3'd1;
                off_grid = (player_y == EDGE_HI);
            end
            MV_DOWN: begin
                tgt_y    = player_y - 3'd1;
                off_grid = (player_y == '0);
            end
            MV_LEFT: begin
                tgt_x    = player_x - 3'd1;
                off_grid = (player_x == '0);
            end
            MV_RIGHT: begin
                tgt_x    = player_x + 3'd1;
                off_grid = (player_x == EDGE_HI);
            end
        endcase
    end

    // column m of map m is blocked on odd rows, the destination never is
    assign tgt_is_dest = (tgt_x == dest_x) && (tgt_y == dest_y);
    assign obstacle    = (tgt_x == map_select) && tgt_y[0] && !tgt_is_dest;

    assign new_x      = (off_grid || obstacle) ? player_x : tgt_x;
    assign new_y      = (off_grid || obstacle) ? player_y : tgt_y;
    assign next_count = move_count + 1'b1;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            game_state <= MENU;
            player_x   <= coord_t'(`MAZE_RST_START_X);
            player_y   <= coord_t'(`MAZE_RST_START_Y);
            move_count <= '0;
        end else begin
            case (game_state)
                MENU: if (start) game_state <= LOAD;
                LOAD: begin
                    player_x   <= start_x;
                    player_y   <= start_y;
                    move_count <= '0;
                    game_state <= PLAY;
                end
                PLAY: if (q_valid) begin
                    player_x   <= new_x;
                    player_y   <= new_y;
                    move_count <= next_count;
                    if ((new_x == dest_x) && (new_y == dest_y)) begin
                        game_state <= WON;    // a win beats running out of moves
                    end else if (next_count == `MAZE_CNT_W'(`MAZE_MAX_MOVES)) begin
                        game_state <= LOST;
                    end
                end
                WON, LOST: if (start) game_state <= MENU;
                default: game_state <= MENU;
            endcase
        end
    end

endmodule

`default_nettype wire
